// ==== tb.f ====
src/mister_cfg_pkg.sv
src/ddr_req_if.sv
src/status_regs.sv
src/sync_resync.sv
src/ddr_port_mux.sv
src/mister_frame_top.sv
testbench/tb_clkgen.sv
testbench/tb_mister_frame.sv

// ==== testbench/tb_mister_frame.sv ====
// Testbench for mister_frame_top. Concurrent assertions compare the DUT with
// reference models of the register contents, the sync history and the DDR owner.
// Inputs change 2 ns after the rising edge; AXI tasks watch handshakes at negedge.
`timescale 1ns/100ps
`default_nettype none

module tb_mister_frame
    import mister_cfg_pkg::*;
;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int SEED        = 42;
    localparam int DELAY_TAPS  = 16;
    localparam int N_ITER      = 10;
    localparam int N_PAIRS     = 6;
    localparam int SYNC_CYCLES = 120;
    localparam int DDR_CYCLES  = 800;
    // Rough cycle count of all tests, doubled for the watchdog
    localparam int BUDGET_CYCLES = N_ITER * 80 + N_PAIRS * (SYNC_CYCLES + 10) + DDR_CYCLES + 50;

    logic clk_sys, arst_n;
    axil_addr_t s_awaddr, s_araddr;
    axil_data_t s_wdata, s_rdata;
    logic [3:0] s_wstrb;
    logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic s_arvalid, s_arready, s_rvalid, s_rready;
    axi_resp_e s_bresp, s_rresp;
    logic pxl_cen, hs, vs, hs_out, vs_out;
    offset_t hoffset, voffset;
    logic hsize_enable, shadowmask_2x, shadowmask_rot, db15_en;
    logic [3:0] hsize_scale;
    logic [2:0] shadowmask;
    menumask_t menumask;
    core_mod_t core_mod;
    logic downloading, ld_rd, ld_busy, rot_rd, rot_we, rot_busy;
    ddr_burst_t ld_burstcnt, rot_burstcnt, ddr_burstcnt;
    ddr_addr_t ld_addr, rot_addr, ddr_addr;
    ddr_be_t rot_be, ddr_be;
    logic ddr_busy, ddr_rd, ddr_we;

    // Reference state
    status_word_t exp_status;
    core_mod_t    exp_core_mod;
    menumask_t    exp_menumask;
    axi_resp_e    exp_bresp, exp_rresp;
    axil_data_t   exp_rdata;
    logic [DELAY_TAPS-1:0] hs_hist;  // Newest pixel sample at bit 0
    logic [15:0]  vs_hist;           // One entry per hs rising edge
    logic         hs_prev;
    ddr_owner_e   exp_owner;
    logic [31:0]  rng;
    int err_count, err_mark, tests_run;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(3)) u_tb_clkgen (.clk_sys, .arst_n);

    mister_frame_top #(.DELAY_TAPS(DELAY_TAPS)) u_mister_frame_top (.*);

    assign exp_menumask = {11'd0, ~exp_core_mod[0], exp_status[34:32] == 3'd0,
                           ~exp_status[19], 2'b00};

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_hist <= '0;
            vs_hist <= '0;
            hs_prev <= 1'b0;
        end else if (pxl_cen) begin
            hs_hist <= {hs_hist[DELAY_TAPS-2:0], hs};
            hs_prev <= hs;
            if (hs && !hs_prev) vs_hist <= {vs_hist[14:0], vs};
        end
    end

    // Owner follows downloading, moving only while the current owner is idle
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n)
            exp_owner <= OWNER_LOADER;
        else if (exp_owner == OWNER_LOADER ? !ld_rd : !(rot_rd || rot_we))
            exp_owner <= downloading ? OWNER_LOADER : OWNER_ROTATOR;
    end

    task automatic log_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        err_count++;
    endtask

    a_bresp: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_bvalid |-> s_bresp == exp_bresp)
        else log_failure("write response");
    a_b_latency: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_awvalid && s_awready && s_wvalid && s_wready |=> s_bvalid)
        else log_failure("bvalid late after write handshake");
    a_rdata: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_rvalid && s_rready |-> s_rdata == exp_rdata && s_rresp == exp_rresp)
        else log_failure($sformatf("read data %h, expected %h",
                                   $sampled(s_rdata), $sampled(exp_rdata)));
    a_r_latency: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_arvalid && s_arready |=> s_rvalid)
        else log_failure("rvalid late after read address handshake");
    a_arready: assert property (@(posedge clk_sys) disable iff (!arst_n)
        !s_rvalid |-> s_arready)
        else log_failure("arready low while no read pending");
    a_b_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
        else log_failure("bvalid dropped early");
    a_r_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else log_failure("read data not held");
    a_no_accept: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_bvalid |-> !s_awready && !s_wready)
        else log_failure("write accepted during response");
    a_decode: assert property (@(posedge clk_sys) disable iff (!arst_n)
        hsize_enable == exp_status[19] && hsize_scale == exp_status[23:20] &&
        hoffset == exp_status[27:24] && voffset == exp_status[31:28] &&
        shadowmask == exp_status[34:32] && shadowmask_2x == exp_status[35] &&
        shadowmask_rot == (exp_core_mod[0] ^ exp_status[36]) && db15_en == exp_status[37] &&
        core_mod == exp_core_mod && menumask == exp_menumask)
        else log_failure("decoded controls");
    a_hs: assert property (@(posedge clk_sys) disable iff (!arst_n)
        hs_out == hs_hist[exp_status[27:24]])
        else log_failure("hs_out");
    a_vs: assert property (@(posedge clk_sys) disable iff (!arst_n)
        vs_out == vs_hist[exp_status[31:28]])
        else log_failure("vs_out");
    a_port_loader: assert property (@(posedge clk_sys) disable iff (!arst_n)
        exp_owner == OWNER_LOADER |-> ddr_rd == ld_rd && !ddr_we && ddr_addr == ld_addr &&
        ddr_burstcnt == ld_burstcnt && ld_busy == ddr_busy && rot_busy)
        else log_failure("port while loader owns");
    a_port_rotator: assert property (@(posedge clk_sys) disable iff (!arst_n)
        exp_owner == OWNER_ROTATOR |-> ddr_rd == rot_rd && ddr_we == rot_we &&
        ddr_addr == rot_addr && ddr_burstcnt == rot_burstcnt && ddr_be == rot_be &&
        rot_busy == ddr_busy && ld_busy)
        else log_failure("port while rotator owns");

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                             input logic [3:0] strb, input int hold);
        logic aw_left;
        logic w_left;
        exp_bresp = (addr == REG_STATUS_LO || addr == REG_STATUS_HI ||
                     addr == REG_CORE_MOD) ? RESP_OKAY : RESP_SLVERR;
        aw_left   = 1'b1;
        w_left    = 1'b1;
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = strb;
        s_wvalid  = 1'b1;
        while (aw_left || w_left) begin
            @(negedge clk_sys);
            if (s_awvalid && s_awready) aw_left = 1'b0;
            if (s_wvalid && s_wready) w_left = 1'b0;
            @(posedge clk_sys);
            #DRIVE_DLY;
            if (!aw_left) s_awvalid = 1'b0;
            if (!w_left) s_wvalid = 1'b0;
        end
        // Register takes the new value on the edge that raised bvalid
        for (int i = 0; i < 4; i++) begin
            if (strb[i] && addr == REG_STATUS_LO) exp_status[8*i +: 8] = data[8*i +: 8];
            if (strb[i] && addr == REG_STATUS_HI) exp_status[32+8*i +: 8] = data[8*i +: 8];
        end
        if (addr == REG_CORE_MOD && strb[0]) exp_core_mod = data[6:0];
        repeat (hold) begin
            @(posedge clk_sys);
            #DRIVE_DLY;
        end
        s_bready = 1'b1;
        @(negedge clk_sys);
        while (!s_bvalid) @(negedge clk_sys);
        @(posedge clk_sys);
        #DRIVE_DLY;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, input int hold);
        exp_rresp = RESP_OKAY;
        case (addr)
            REG_STATUS_LO: exp_rdata = exp_status[31:0];
            REG_STATUS_HI: exp_rdata = exp_status[63:32];
            REG_CORE_MOD:  exp_rdata = {25'd0, exp_core_mod};
            default:       exp_rdata = {16'd0, exp_menumask};
        endcase
        s_araddr  = addr;
        s_arvalid = 1'b1;
        @(negedge clk_sys);
        while (!s_arready) @(negedge clk_sys);
        @(posedge clk_sys);
        #DRIVE_DLY;
        s_arvalid = 1'b0;
        repeat (hold) begin
            @(posedge clk_sys);
            #DRIVE_DLY;
        end
        s_rready = 1'b1;
        @(negedge clk_sys);
        while (!s_rvalid) @(negedge clk_sys);
        @(posedge clk_sys);
        #DRIVE_DLY;
        s_rready = 1'b0;
    endtask

    task automatic read_all_regs();
        axi_read(REG_STATUS_LO, 0);
        axi_read(REG_STATUS_HI, 0);
        axi_read(REG_CORE_MOD, 0);
    endtask

    task automatic sync_cycle();
        logic [31:0] r;
        r = next_rand();
        pxl_cen = (r[1:0] != 2'd0);
        if (pxl_cen) hs = r[2];
        if (r[7:3] == 5'd0) vs = !vs;   // Frame sync changes rarely
        @(posedge clk_sys);
        #DRIVE_DLY;
    endtask

    // Requesters hold a request until a cycle in which their busy is low
    task automatic ddr_cycle();
        logic ld_taken;
        logic rot_taken;
        logic [31:0] r;
        @(negedge clk_sys);
        ld_taken  = ld_rd && !ld_busy;
        rot_taken = (rot_rd || rot_we) && !rot_busy;
        @(posedge clk_sys);
        #DRIVE_DLY;
        r = next_rand();
        ddr_busy = (r[1:0] == 2'd0);
        if (!ld_rd || ld_taken) begin
            ld_rd       = downloading && r[2];
            ld_burstcnt = r[10:3];
            ld_addr     = {r[31:11], r[7:0]};
        end
        if (!(rot_rd || rot_we) || rot_taken) begin
            r = next_rand();
            rot_rd       = r[1] && r[0];
            rot_we       = r[1] && !r[0];
            rot_be       = r[9:2];
            rot_burstcnt = r[17:10];
            rot_addr     = {r[31:18], r[14:0]};
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %0d %s: %0d errors", tests_run, name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin : watchdog
        #(2 * BUDGET_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", 2 * BUDGET_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        rng = SEED;
        err_count = 0;
        err_mark = 0;
        tests_run = 0;
        exp_status = '0;
        exp_core_mod = '0;
        exp_bresp = RESP_OKAY;
        exp_rresp = RESP_OKAY;
        exp_rdata = '0;
        {s_awaddr, s_awvalid, s_wdata, s_wstrb, s_wvalid, s_bready} = '0;
        {s_araddr, s_arvalid, s_rready} = '0;
        {pxl_cen, hs, vs, downloading, ddr_busy} = '0;
        {ld_burstcnt, ld_addr, ld_rd} = '0;
        {rot_burstcnt, rot_addr, rot_rd, rot_we, rot_be} = '0;
        wait (arst_n);
        @(posedge clk_sys);
        #DRIVE_DLY;

        for (int i = 0; i < N_ITER; i++) begin
            r = next_rand();
            axi_write(REG_STATUS_LO, next_rand(), r[3:0], 0);
            axi_write(REG_STATUS_HI, next_rand(), r[7:4], 0);
            axi_write(REG_CORE_MOD, next_rand(), r[11:8] | 4'b0001, 0);
            read_all_regs();
            axi_write(REG_MENUMASK, next_rand(), 4'hF, 0);
            axi_write({r[13:12], 2'b01}, next_rand(), 4'hF, 0);   // Unmapped
            read_all_regs();
        end
        finish_test("register access");

        axi_write(REG_STATUS_HI, next_rand(), 4'hF, 6);
        axi_read(REG_STATUS_HI, 6);
        axi_write(REG_MENUMASK, next_rand(), 4'hF, 4);
        axi_read(REG_CORE_MOD, 5);
        finish_test("back-pressure");

        for (int i = 0; i < N_ITER; i++) begin
            axi_write(REG_STATUS_LO, next_rand(), 4'hF, 0);
            axi_write(REG_STATUS_HI, next_rand(), 4'hF, 0);
            axi_write(REG_CORE_MOD, next_rand(), 4'hF, 0);
            axi_read(REG_MENUMASK, 0);
        end
        finish_test("decoding");

        for (int p = 0; p < N_PAIRS; p++) begin
            r = next_rand();
            axi_write(REG_STATUS_LO, {r[7:0], 24'h0}, 4'b1000, 0);   // voffset, hoffset
            repeat (SYNC_CYCLES) sync_cycle();
        end
        pxl_cen = 1'b0;
        finish_test("resync");

        downloading = 1'b1;
        for (int i = 0; i < DDR_CYCLES; i++) begin
            if (i % 40 == 20) downloading = !downloading;
            ddr_cycle();
        end
        {ld_rd, rot_rd, rot_we, ddr_busy} = '0;
        repeat (4) @(posedge clk_sys);
        finish_test("DDR multiplexing");

        $display("Tests run: %0d, failed checks: %0d", tests_run, err_count);
        if (err_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
// Free-running clk_sys and a power-on reset for the testbench.
// Reset is released a little after a rising edge, never on it.
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk_sys,
    output logic arst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #2 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/mister_frame_top.sv ====
// Frame wrapper top: status registers, sync resync and DDR port sharing.
// Single clock domain; the loader is read only.
`timescale 1ns/100ps
`default_nettype none

module mister_frame_top
    import mister_cfg_pkg::*;
#(
    parameter int DELAY_TAPS = 16    // Horizontal sync delay line length
) (
    input  logic       clk_sys,
    input  logic       arst_n,
    // AXI4-Lite host
    input  axil_addr_t s_awaddr,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  axil_data_t s_wdata,
    input  logic [3:0] s_wstrb,
    input  logic       s_wvalid,
    output logic       s_wready,
    output logic       s_bvalid,
    output axi_resp_e  s_bresp,
    input  logic       s_bready,
    input  axil_addr_t s_araddr,
    input  logic       s_arvalid,
    output logic       s_arready,
    output logic       s_rvalid,
    output axil_data_t s_rdata,
    output axi_resp_e  s_rresp,
    input  logic       s_rready,
    // Video sync
    input  logic       pxl_cen,
    input  logic       hs,
    input  logic       vs,
    output logic       hs_out,
    output logic       vs_out,
    // Decoded controls
    output offset_t    hoffset,
    output offset_t    voffset,
    output logic       hsize_enable,
    output logic [3:0] hsize_scale,
    output logic [2:0] shadowmask,
    output logic       shadowmask_2x,
    output logic       shadowmask_rot,
    output logic       db15_en,
    output menumask_t  menumask,
    output core_mod_t  core_mod,
    // DDR requesters
    input  logic       downloading,
    input  ddr_burst_t ld_burstcnt,
    input  ddr_addr_t  ld_addr,
    input  logic       ld_rd,
    output logic       ld_busy,
    input  ddr_burst_t rot_burstcnt,
    input  ddr_addr_t  rot_addr,
    input  logic       rot_rd,
    input  logic       rot_we,
    input  ddr_be_t    rot_be,
    output logic       rot_busy,
    // DDR port
    input  logic       ddr_busy,
    output ddr_burst_t ddr_burstcnt,
    output ddr_addr_t  ddr_addr,
    output logic       ddr_rd,
    output logic       ddr_we,
    output ddr_be_t    ddr_be
);

    ddr_req_if u_ld_if ();
    ddr_req_if u_rot_if ();

    assign u_ld_if.burstcnt  = ld_burstcnt;
    assign u_ld_if.addr      = ld_addr;
    assign u_ld_if.rd        = ld_rd;
    assign u_ld_if.we        = 1'b0;     // Loader never writes
    assign u_ld_if.be        = '1;
    assign ld_busy           = u_ld_if.busy;

    assign u_rot_if.burstcnt = rot_burstcnt;
    assign u_rot_if.addr     = rot_addr;
    assign u_rot_if.rd       = rot_rd;
    assign u_rot_if.we       = rot_we;
    assign u_rot_if.be       = rot_be;
    assign rot_busy          = u_rot_if.busy;

    status_regs u_status_regs (.*);

    sync_resync #(.DELAY_TAPS(DELAY_TAPS)) u_sync_resync (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .vs      (vs),
        .hoffset (hoffset),
        .voffset (voffset),
        .hs_out  (hs_out),
        .vs_out  (vs_out)
    );

    ddr_port_mux u_ddr_port_mux (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .downloading  (downloading),
        .loader       (u_ld_if),
        .rotator      (u_rot_if),
        .ddr_busy     (ddr_busy),
        .ddr_burstcnt (ddr_burstcnt),
        .ddr_addr     (ddr_addr),
        .ddr_rd       (ddr_rd),
        .ddr_we       (ddr_we),
        .ddr_be       (ddr_be)
    );

endmodule

`default_nettype wire

// ==== src/ddr_port_mux.sv ====
// Shares one DDR request port between the ROM loader and the screen rotator.
// Ownership follows downloading but only moves while the owner is idle.
// No added latency; the non-owner always sees busy.
`timescale 1ns/100ps
`default_nettype none

module ddr_port_mux
    import mister_cfg_pkg::*;
(
    input  logic          clk_sys,
    input  logic          arst_n,
    input  logic          downloading,
    ddr_req_if.mux        loader,
    ddr_req_if.mux        rotator,
    input  logic          ddr_busy,
    output ddr_burst_t    ddr_burstcnt,
    output ddr_addr_t     ddr_addr,
    output logic          ddr_rd,
    output logic          ddr_we,
    output ddr_be_t       ddr_be
);

    ddr_owner_e owner;
    ddr_owner_e owner_want;
    logic       owner_idle;

    assign owner_want = downloading ? OWNER_LOADER : OWNER_ROTATOR;
    assign owner_idle = (owner == OWNER_LOADER) ? !(loader.rd || loader.we)
                                                : !(rotator.rd || rotator.we);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n)
            owner <= OWNER_LOADER;
        else if (owner_idle)
            owner <= owner_want;   // Never cut a request short
    end

    always_comb begin
        if (owner == OWNER_LOADER) begin
            ddr_burstcnt = loader.burstcnt;
            ddr_addr     = loader.addr;
            ddr_rd       = loader.rd;
            ddr_we       = loader.we;
            ddr_be       = loader.be;
        end else begin
            ddr_burstcnt = rotator.burstcnt;
            ddr_addr     = rotator.addr;
            ddr_rd       = rotator.rd;
            ddr_we       = rotator.we;
            ddr_be       = rotator.be;
        end
    end

    assign loader.busy  = (owner == OWNER_LOADER) ? ddr_busy : 1'b1;
    assign rotator.busy = (owner == OWNER_ROTATOR) ? ddr_busy : 1'b1;

    a_owner_switch_idle: assert property (@(posedge clk_sys) disable iff (!arst_n)
        $changed(owner) |-> $past(owner_idle));
    a_no_rd_we: assert property (@(posedge clk_sys) disable iff (!arst_n)
        !(ddr_rd && ddr_we));

endmodule

`default_nettype wire

// ==== src/sync_resync.sv ====
// Moves sync pulses for CRT centring.
// hoffset must stay below DELAY_TAPS; voffset always fits its own line.
`timescale 1ns/100ps
`default_nettype none

module sync_resync
    import mister_cfg_pkg::*;
#(
    parameter int DELAY_TAPS = 16
) (
    input  logic    clk_sys,
    input  logic    arst_n,
    input  logic    pxl_cen,
    input  logic    hs,
    input  logic    vs,
    input  offset_t hoffset,
    input  offset_t voffset,
    output logic    hs_out,
    output logic    vs_out
);

    localparam int V_TAPS = 2**OFFSET_W;  // Every voffset value reachable

    logic [DELAY_TAPS-1:0] hs_line;   // One tap per pixel
    logic [V_TAPS-1:0]     vs_line;   // One tap per line
    logic                  hs_last;
    logic                  hs_rise;

    assign hs_rise = pxl_cen && hs && !hs_last;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_line <= '0;
            vs_line <= '0;
            hs_last <= 1'b0;
        end else begin
            if (pxl_cen) begin
                hs_line <= {hs_line[DELAY_TAPS-2:0], hs};
                hs_last <= hs;
            end
            if (hs_rise)
                vs_line <= {vs_line[V_TAPS-2:0], vs};
        end
    end

    // Tap 0 already holds one sample of delay
    assign hs_out = hs_line[hoffset];
    assign vs_out = vs_line[voffset];

    // The offset comes from the status block, which knows nothing of the line length
    a_hoffset_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
        hoffset < DELAY_TAPS);

endmodule

`default_nettype wire

// ==== src/status_regs.sv ====
// AXI4-Lite register block for the OSD status word and core mode bits.
// Address and data channels may arrive in either order; one write in flight.
// Unmapped or read-only targets answer SLVERR and leave state untouched.
`timescale 1ns/100ps
`default_nettype none

module status_regs
    import mister_cfg_pkg::*;
(
    input  logic       clk_sys,
    input  logic       arst_n,
    input  axil_addr_t s_awaddr,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  axil_data_t s_wdata,
    input  logic [3:0] s_wstrb,
    input  logic       s_wvalid,
    output logic       s_wready,
    output logic       s_bvalid,
    output axi_resp_e  s_bresp,
    input  logic       s_bready,
    input  axil_addr_t s_araddr,
    input  logic       s_arvalid,
    output logic       s_arready,
    output logic       s_rvalid,
    output axil_data_t s_rdata,
    output axi_resp_e  s_rresp,
    input  logic       s_rready,
    output offset_t    hoffset,
    output offset_t    voffset,
    output logic       hsize_enable,
    output logic [3:0] hsize_scale,
    output logic [2:0] shadowmask,
    output logic       shadowmask_2x,
    output logic       shadowmask_rot,
    output logic       db15_en,
    output menumask_t  menumask,
    output core_mod_t  core_mod
);

    status_word_t status;
    logic         aw_done, w_done;   // Channel accepted, waiting for its partner
    axil_addr_t   aw_addr_q;
    axil_data_t   w_data_q;
    logic [3:0]   w_strb_q;
    logic         aw_hs, w_hs, ar_hs;
    logic         wr_go, wr_ok;
    axil_addr_t   wr_addr;
    axil_data_t   wr_data;
    logic [3:0]   wr_strb;

    assign s_awready = !aw_done && !s_bvalid;
    assign s_wready  = !w_done && !s_bvalid;
    assign s_arready = !s_rvalid;

    assign aw_hs = s_awvalid && s_awready;
    assign w_hs  = s_wvalid && s_wready;
    assign ar_hs = s_arvalid && s_arready;

    // Commit as soon as both halves are in hand, held or arriving now
    assign wr_go   = (aw_done || aw_hs) && (w_done || w_hs);
    assign wr_addr = aw_done ? aw_addr_q : s_awaddr;
    assign wr_data = w_done ? w_data_q : s_wdata;
    assign wr_strb = w_done ? w_strb_q : s_wstrb;
    assign wr_ok   = (wr_addr == REG_STATUS_LO) || (wr_addr == REG_STATUS_HI) ||
                     (wr_addr == REG_CORE_MOD);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
            status   <= '0;
            core_mod <= '0;
        end else begin
            if (wr_go) begin
                aw_done  <= 1'b0;
                w_done   <= 1'b0;
                s_bvalid <= 1'b1;
                case (wr_addr)
                    REG_STATUS_LO: begin
                        for (int i = 0; i < 4; i++)
                            if (wr_strb[i]) status[8*i +: 8] <= wr_data[8*i +: 8];
                    end
                    REG_STATUS_HI: begin
                        for (int i = 0; i < 4; i++)
                            if (wr_strb[i]) status[32+8*i +: 8] <= wr_data[8*i +: 8];
                    end
                    REG_CORE_MOD: if (wr_strb[0]) core_mod <= wr_data[CORE_MOD_W-1:0];
                    default: ;
                endcase
            end else begin
                if (aw_hs) aw_done <= 1'b1;
                if (w_hs) w_done <= 1'b1;
                if (s_bvalid && s_bready) s_bvalid <= 1'b0;
            end
            if (ar_hs)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (aw_hs) aw_addr_q <= s_awaddr;
        if (w_hs) begin
            w_data_q <= s_wdata;
            w_strb_q <= s_wstrb;
        end
        if (wr_go) s_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (ar_hs) begin
            s_rresp <= RESP_OKAY;
            case (s_araddr)
                REG_STATUS_LO: s_rdata <= status[31:0];
                REG_STATUS_HI: s_rdata <= status[63:32];
                REG_CORE_MOD:  s_rdata <= {{(AXIL_DATA_W-CORE_MOD_W){1'b0}}, core_mod};
                REG_MENUMASK:  s_rdata <= {16'h0000, menumask};
                default: begin
                    s_rdata <= '0;
                    s_rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    // Field decode
    assign hsize_enable   = status[ST_HSIZE_EN];
    assign hsize_scale    = status[ST_HSIZE_SCALE_LSB +: ST_HSIZE_SCALE_W];
    assign hoffset        = status[ST_HOFFSET_LSB +: OFFSET_W];
    assign voffset        = status[ST_VOFFSET_LSB +: OFFSET_W];
    assign shadowmask     = status[ST_SHADOW_LSB +: ST_SHADOW_W];
    assign shadowmask_2x  = status[ST_SHADOW_2X];
    assign shadowmask_rot = core_mod[0] ^ status[ST_SHADOW_ROT];
    assign db15_en        = status[ST_DB15];

    always_comb begin
        menumask    = '0;
        menumask[4] = ~core_mod[0];          // Rotation items for vertical games
        menumask[3] = (shadowmask == 3'd0);  // Shadowmask filter off
        menumask[2] = ~hsize_enable;         // Scale factor only when enabled
    end

    a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_bvalid && !s_bready |=> s_bvalid);
    a_rvalid_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

`default_nettype wire

// ==== src/ddr_req_if.sv ====
// One requester's view of the shared DDR port.
// The requester holds its request while busy is high.
`timescale 1ns/100ps
`default_nettype none

interface ddr_req_if
    import mister_cfg_pkg::*;
();
    ddr_burst_t burstcnt;
    ddr_addr_t  addr;
    logic       rd;
    logic       we;
    ddr_be_t    be;
    logic       busy;     // Also high while another requester owns the port

    modport requester (
        output burstcnt, addr, rd, we, be,
        input  busy
    );

    modport mux (
        input  burstcnt, addr, rd, we, be,
        output busy
    );

endinterface

`default_nettype wire

// ==== src/mister_cfg_pkg.sv ====
// Shared widths, register map and status word layout for the frame wrapper.
// Register addresses assume word-aligned AXI4-Lite accesses only.
`default_nettype none

package mister_cfg_pkg;

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;
    localparam int STATUS_W    = 64;
    localparam int CORE_MOD_W  = 7;
    localparam int OFFSET_W    = 4;    // Sync offsets span 0..15

    typedef logic [STATUS_W-1:0]    status_word_t;
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [CORE_MOD_W-1:0]  core_mod_t;  // Bit 0 set for vertical games
    typedef logic [OFFSET_W-1:0]    offset_t;
    typedef logic [28:0]            ddr_addr_t;  // 64-bit word address
    typedef logic [7:0]             ddr_burst_t;
    typedef logic [7:0]             ddr_be_t;
    typedef logic [15:0]            menumask_t;  // 1 hides the item

    typedef enum logic {OWNER_LOADER, OWNER_ROTATOR} ddr_owner_e;
    typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axi_resp_e;

    localparam axil_addr_t REG_STATUS_LO = 4'h0;
    localparam axil_addr_t REG_STATUS_HI = 4'h4;
    localparam axil_addr_t REG_CORE_MOD  = 4'h8;
    localparam axil_addr_t REG_MENUMASK  = 4'hC;  // Read only

    // Field positions inside the OSD status word
    localparam int ST_HSIZE_EN        = 19;
    localparam int ST_HSIZE_SCALE_LSB = 20;
    localparam int ST_HSIZE_SCALE_W   = 4;
    localparam int ST_HOFFSET_LSB     = 24;
    localparam int ST_VOFFSET_LSB     = 28;
    localparam int ST_SHADOW_LSB      = 32;
    localparam int ST_SHADOW_W        = 3;
    localparam int ST_SHADOW_2X       = 35;
    localparam int ST_SHADOW_ROT      = 36;
    localparam int ST_DB15            = 37;

endpackage

`default_nettype wire
